/* hw/policer_pkg.sv */
/* Widths, descriptor field types and constants shared by the policer RTL and its testbench.
   Referenced by scoped name; nothing here is imported. */
`default_nettype none

package policer_pkg;

    //////////////////////////////
    // Descriptor fields
    //////////////////////////////

    // Up to 16 ingress or egress ports
    localparam int PORT_W = 4;

    typedef logic [PORT_W-1:0] port_t;

    // Scheduler priority, carried through untouched
    typedef logic [2:0] prio_t;

    // Packet length in bytes, wide enough for the MTU
    typedef logic [10:0] byte_len_t;

    localparam int MTU_BYTES     = 1500;
    localparam int MIN_PKT_BYTES = 64;

    //////////////////////////////
    // Rate and bucket
    //////////////////////////////

    // Fraction bits shared by the CIR and the bucket fill
    localparam int RATE_FRAC_W = 8;

    // CIR leak per clock, 8 whole bits then 8 fraction bits
    typedef logic [15:0] rate_t;

    // CBS threshold, also the whole-byte part of a bucket
    typedef logic [19:0] depth_t;

    // Bucket content: whole bytes on top, fraction below
    typedef logic [$bits(depth_t)+RATE_FRAC_W-1:0] fill_t;

    //////////////////////////////
    // Configuration strobe
    //////////////////////////////

    typedef logic cfg_sel_t;

    localparam cfg_sel_t CFG_SEL_CIR = 1'b0;
    localparam cfg_sel_t CFG_SEL_CBS = 1'b1;

endpackage

`default_nettype wire

/* hw/policer_bucket_if.sv */
/* Read and accept-update path between the marking pipeline and the bucket bank.
   No clock inside; the update lands on the bank's next edge. */
`default_nettype none

interface policer_bucket_if ();

    // Read side, fill is combinational after this cycle's leak
    policer_pkg::port_t     rd_port;
    policer_pkg::depth_t    rd_fill;

    // One-cycle accept strobe, no handshake
    logic                   upd_valid;
    policer_pkg::port_t     upd_port;
    policer_pkg::byte_len_t upd_bytes;

    modport bucket (
        input  rd_port,
        input  upd_valid,
        input  upd_port,
        input  upd_bytes,
        output rd_fill
    );

    modport marker (
        output rd_port,
        output upd_valid,
        output upd_port,
        output upd_bytes,
        input  rd_fill
    );

endinterface

`default_nettype wire

/* hw/policer_config_regs.sv */
/* Per-port CIR and CBS tables, loaded one entry at a time by the cfg_write strobe.
   Both tables are presented in full to the bucket bank and the marker. */
`default_nettype none

module policer_config_regs #(
    parameter int NUM_PORTS = 11
) (
    input  logic                  core_clk_ifc,
    input  logic                  timer_reset,

    input  logic                  cfg_write,
    input  policer_pkg::cfg_sel_t cfg_sel,
    input  policer_pkg::port_t    cfg_port,
    input  logic [31:0]           cfg_data,

    output policer_pkg::rate_t    cir_table [NUM_PORTS],
    output policer_pkg::depth_t   cbs_table [NUM_PORTS]
);

    logic                port_in_range;
    logic                cir_wr;
    logic                cbs_wr;
    policer_pkg::rate_t  cir_wdata;
    policer_pkg::depth_t cbs_wdata;

    // Ports past the last physical port are silently dropped
    assign port_in_range = int'(cfg_port) < NUM_PORTS;

    assign cir_wr = cfg_write && port_in_range && (cfg_sel == policer_pkg::CFG_SEL_CIR);
    assign cbs_wr = cfg_write && port_in_range && (cfg_sel == policer_pkg::CFG_SEL_CBS);

    // Low bits of the data word only
    assign cir_wdata = cfg_data[$bits(policer_pkg::rate_t)-1:0];
    assign cbs_wdata = cfg_data[$bits(policer_pkg::depth_t)-1:0];

    //////////////////////////////
    // Table registers
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                cir_table[i] <= '0;
                cbs_table[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                // Per-entry decode of the written port
                if (cir_wr && (cfg_port == policer_pkg::port_t'(i))) begin
                    cir_table[i] <= cir_wdata;
                end
                if (cbs_wr && (cfg_port == policer_pkg::port_t'(i))) begin
                    cbs_table[i] <= cbs_wdata;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/policer_bucket_bank.sv */
/* One token bucket per ingress port, leaking by its CIR every clock and filled by accepts.
   Serves the marker a combinational whole-byte read of the leaked fill. */
`default_nettype none

module policer_bucket_bank #(
    parameter int NUM_PORTS = 11
) (
    input  logic                    core_clk_ifc,
    input  logic                    timer_reset,

    input  policer_pkg::rate_t      cir_table [NUM_PORTS],

    policer_bucket_if.bucket        bkt
);

    localparam int FILL_W = $bits(policer_pkg::fill_t);

    policer_pkg::fill_t fill   [NUM_PORTS];
    policer_pkg::fill_t leaked [NUM_PORTS];
    policer_pkg::fill_t gain;

    //////////////////////////////
    // Per-cycle leak
    //////////////////////////////

    // Subtract the CIR, floor at zero
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (fill[i] > policer_pkg::fill_t'(cir_table[i])) begin
                leaked[i] = fill[i] - policer_pkg::fill_t'(cir_table[i]);
            end else begin
                leaked[i] = '0;
            end
        end
    end

    // Accepted length lands in the whole-byte part
    assign gain = policer_pkg::fill_t'(bkt.upd_bytes) << policer_pkg::RATE_FRAC_W;

    //////////////////////////////
    // Bucket registers
    //////////////////////////////

    // Marker only accepts when fill + length <= CBS, so the add
    // cannot carry out of the fill width
    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                fill[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (bkt.upd_valid && (bkt.upd_port == policer_pkg::port_t'(i))) begin
                    fill[i] <= leaked[i] + gain;
                end else begin
                    fill[i] <= leaked[i];
                end
            end
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Out-of-range ports read as empty
    always_comb begin
        bkt.rd_fill = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (bkt.rd_port == policer_pkg::port_t'(i)) begin
                bkt.rd_fill = leaked[i][FILL_W-1:policer_pkg::RATE_FRAC_W];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/policer_marker.sv */
/* Two-stage descriptor pipeline: stage 1 looks up enable and CBS, stage 2 reads the bucket,
   sets the drop mark and sends the accept update. */
`default_nettype none

module policer_marker #(
    parameter int NUM_PORTS = 11
) (
    input  logic                   core_clk_ifc,
    input  logic                   timer_reset,

    input  logic                   pkt_valid,
    input  policer_pkg::port_t     pkt_ingress_port,
    input  policer_pkg::port_t     pkt_egress_port,
    input  policer_pkg::prio_t     pkt_prio,
    input  policer_pkg::byte_len_t pkt_byte_length,

    input  logic [NUM_PORTS-1:0]   port_enable,
    input  policer_pkg::depth_t    cbs_table [NUM_PORTS],

    policer_bucket_if.marker       bkt,

    output logic                   out_valid,
    output policer_pkg::port_t     out_ingress_port,
    output policer_pkg::port_t     out_egress_port,
    output policer_pkg::prio_t     out_prio,
    output policer_pkg::byte_len_t out_byte_length,
    output logic                   out_drop_mark
);

    // One spare bit so fill + length cannot wrap
    localparam int TOTAL_W = $bits(policer_pkg::depth_t) + 1;

    // Length field must hold a full MTU
    if (policer_pkg::MTU_BYTES >= 2 ** $bits(policer_pkg::byte_len_t)) begin : g_len_check
        $error("byte_len_t is too narrow for MTU_BYTES");
    end

    logic                   lkp_enable;
    policer_pkg::depth_t    lkp_cbs;

    logic                   s1_valid;
    policer_pkg::port_t     s1_ingress;
    policer_pkg::port_t     s1_egress;
    policer_pkg::prio_t     s1_prio;
    policer_pkg::byte_len_t s1_len;
    logic                   s1_enable;
    policer_pkg::depth_t    s1_cbs;

    logic [TOTAL_W-1:0]     s2_total;
    logic                   s2_mark;

    //////////////////////////////
    // Stage 1
    //////////////////////////////

    // Unknown ports look disabled
    always_comb begin
        lkp_enable = 1'b0;
        lkp_cbs    = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (pkt_ingress_port == policer_pkg::port_t'(i)) begin
                lkp_enable = port_enable[i];
                lkp_cbs    = cbs_table[i];
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pkt_valid;
        end
        s1_ingress <= pkt_ingress_port;
        s1_egress  <= pkt_egress_port;
        s1_prio    <= pkt_prio;
        s1_len     <= pkt_byte_length;
        s1_enable  <= lkp_enable;
        s1_cbs     <= lkp_cbs;
    end

    //////////////////////////////
    // Stage 2
    //////////////////////////////

    // Bucket already reflects an accept from the previous cycle
    assign bkt.rd_port = s1_ingress;
    assign s2_total    = TOTAL_W'(bkt.rd_fill) + TOTAL_W'(s1_len);
    assign s2_mark     = s1_enable && (s2_total > TOTAL_W'(s1_cbs));

    // Disabled ports never fill their bucket
    assign bkt.upd_valid = s1_valid && s1_enable && !s2_mark;
    assign bkt.upd_port  = s1_ingress;
    assign bkt.upd_bytes = s1_len;

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            out_valid     <= 1'b0;
            out_drop_mark <= 1'b0;
        end else begin
            out_valid     <= s1_valid;
            out_drop_mark <= s1_valid && s2_mark;
        end
        out_ingress_port <= s1_ingress;
        out_egress_port  <= s1_egress;
        out_prio         <= s1_prio;
        out_byte_length  <= s1_len;
    end

endmodule

`default_nettype wire

/* hw/policer_top.sv */
/* Ingress token-bucket policer: descriptor in, same descriptor plus drop mark out two
   cycles later. Config tables are loaded through a one-cycle write strobe. */
`default_nettype none

module policer_top #(
    parameter int NUM_PORTS = 11
) (
    input  logic                   core_clk_ifc,
    input  logic                   timer_reset,

    // Descriptor in
    input  logic                   pkt_valid,
    input  policer_pkg::port_t     pkt_ingress_port,
    input  policer_pkg::port_t     pkt_egress_port,
    input  policer_pkg::prio_t     pkt_prio,
    input  policer_pkg::byte_len_t pkt_byte_length,

    // Config write strobe
    input  logic                   cfg_write,
    input  policer_pkg::cfg_sel_t  cfg_sel,
    input  policer_pkg::port_t     cfg_port,
    input  logic [31:0]            cfg_data,

    input  logic [NUM_PORTS-1:0]   port_enable,

    // Descriptor out
    output logic                   out_valid,
    output policer_pkg::port_t     out_ingress_port,
    output policer_pkg::port_t     out_egress_port,
    output policer_pkg::prio_t     out_prio,
    output policer_pkg::byte_len_t out_byte_length,
    output logic                   out_drop_mark
);

    // Port numbers are 4 bits wide
    if (NUM_PORTS < 2 || NUM_PORTS > 2 ** policer_pkg::PORT_W) begin : g_ports_check
        $error("NUM_PORTS must be 2 to 16");
    end

    policer_pkg::rate_t  cir_table [NUM_PORTS];
    policer_pkg::depth_t cbs_table [NUM_PORTS];

    policer_bucket_if bkt ();

    //////////////////////////////
    // Blocks
    //////////////////////////////

    policer_config_regs #(
        .NUM_PORTS (NUM_PORTS)
    ) i_config_regs (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cfg_write    (cfg_write),
        .cfg_sel      (cfg_sel),
        .cfg_port     (cfg_port),
        .cfg_data     (cfg_data),
        .cir_table    (cir_table),
        .cbs_table    (cbs_table)
    );

    policer_bucket_bank #(
        .NUM_PORTS (NUM_PORTS)
    ) i_bucket_bank (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cir_table    (cir_table),
        .bkt          (bkt.bucket)
    );

    policer_marker #(
        .NUM_PORTS (NUM_PORTS)
    ) i_marker (
        .core_clk_ifc     (core_clk_ifc),
        .timer_reset      (timer_reset),
        .pkt_valid        (pkt_valid),
        .pkt_ingress_port (pkt_ingress_port),
        .pkt_egress_port  (pkt_egress_port),
        .pkt_prio         (pkt_prio),
        .pkt_byte_length  (pkt_byte_length),
        .port_enable      (port_enable),
        .cbs_table        (cbs_table),
        .bkt              (bkt.marker),
        .out_valid        (out_valid),
        .out_ingress_port (out_ingress_port),
        .out_egress_port  (out_egress_port),
        .out_prio         (out_prio),
        .out_byte_length  (out_byte_length),
        .out_drop_mark    (out_drop_mark)
    );

endmodule

`default_nettype wire

/* tests/policer_tb_asserts.sv */
/* Concurrent checks on the marker pipeline, bound into every policer_marker instance.
   Latency, update versus drop mark, and quiet outputs through reset. */
`default_nettype none

module policer_tb_asserts (
    input logic                   core_clk_ifc,
    input logic                   timer_reset,
    input logic                   pkt_valid,
    input logic                   out_valid,
    input logic                   out_drop_mark,
    input policer_pkg::byte_len_t out_byte_length,
    input logic                   upd_valid
);

    // Exactly two cycles in both directions
    a_latency_fwd: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        pkt_valid |-> ##2 out_valid)
        else $error("out_valid did not follow pkt_valid after two cycles");

    a_latency_back: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid |-> $past(pkt_valid, 2))
        else $error("out_valid without a descriptor two cycles earlier");

    // An accepted packet never leaves marked
    a_upd_not_marked: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        upd_valid |=> !out_drop_mark)
        else $error("bucket update for a marked packet");

    a_reset_quiet: assert property (@(posedge core_clk_ifc)
        timer_reset |=> (!out_valid && !out_drop_mark && !upd_valid))
        else $error("output or update active after a reset edge");

    a_min_len: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid |-> (int'(out_byte_length) >= policer_pkg::MIN_PKT_BYTES))
        else $error("descriptor shorter than the minimum packet");

endmodule

bind policer_marker policer_tb_asserts i_asserts (
    .core_clk_ifc    (core_clk_ifc),
    .timer_reset     (timer_reset),
    .pkt_valid       (pkt_valid),
    .out_valid       (out_valid),
    .out_drop_mark   (out_drop_mark),
    .out_byte_length (out_byte_length),
    .upd_valid       (bkt.upd_valid)
);

`default_nettype wire

/* tests/policer_tb.sv */
/* Table-driven testbench for policer_top. Each phase writes the tables and sends descriptors,
   and a cycle-level token-bucket model predicts every output. */
`default_nettype none

module policer_tb;

    localparam int NUM_PORTS = 11;
    localparam logic [NUM_PORTS-1:0] ALL_PORTS = '1;
    localparam logic [31:0] LFSR_SEED = 32'h51efd105;
    localparam int NUM_PHASES = 5;

    // One row of the stimulus table
    typedef struct packed {
        policer_pkg::rate_t     cir;
        logic                   cir_random;
        policer_pkg::depth_t    cbs;
        logic                   cbs_random;
        logic [NUM_PORTS-1:0]   enable_mask;
        logic                   mask_random;
        int                     pkt_count;
        logic                   len_random;
        policer_pkg::byte_len_t fixed_len;
        int                     gap_after;
        int                     gap_cycles;
        logic                   rate_mode;
    } phase_t;

    // Expected output descriptor
    typedef struct packed {
        policer_pkg::port_t     ingress;
        policer_pkg::port_t     egress;
        policer_pkg::prio_t     prio;
        policer_pkg::byte_len_t len;
        logic                   mark;
    } exp_t;

    logic                   core_clk_ifc;
    logic                   timer_reset;
    logic                   pkt_valid;
    policer_pkg::port_t     pkt_ingress_port;
    policer_pkg::port_t     pkt_egress_port;
    policer_pkg::prio_t     pkt_prio;
    policer_pkg::byte_len_t pkt_byte_length;
    logic                   cfg_write;
    policer_pkg::cfg_sel_t  cfg_sel;
    policer_pkg::port_t     cfg_port;
    logic [31:0]            cfg_data;
    logic [NUM_PORTS-1:0]   port_enable;
    logic                   out_valid;
    policer_pkg::port_t     out_ingress_port;
    policer_pkg::port_t     out_egress_port;
    policer_pkg::prio_t     out_prio;
    policer_pkg::byte_len_t out_byte_length;
    logic                   out_drop_mark;

    phase_t      phases [NUM_PHASES];
    logic [31:0] lfsr_state;
    int          sent_count;
    int          checked_count;
    int          error_count;
    int          cycle_count;
    int          timeout_limit;

    // Reference model state
    policer_pkg::fill_t  m_fill [NUM_PORTS];
    policer_pkg::rate_t  m_cir  [NUM_PORTS];
    policer_pkg::depth_t m_cbs  [NUM_PORTS];
    logic                m_s1_valid;
    logic                m_s1_enable;
    policer_pkg::depth_t m_s1_cbs;
    exp_t                m_s1_desc;
    exp_t                exp_q [$];

    policer_top #(
        .NUM_PORTS (NUM_PORTS)
    ) i_dut (
        .core_clk_ifc     (core_clk_ifc),
        .timer_reset      (timer_reset),
        .pkt_valid        (pkt_valid),
        .pkt_ingress_port (pkt_ingress_port),
        .pkt_egress_port  (pkt_egress_port),
        .pkt_prio         (pkt_prio),
        .pkt_byte_length  (pkt_byte_length),
        .cfg_write        (cfg_write),
        .cfg_sel          (cfg_sel),
        .cfg_port         (cfg_port),
        .cfg_data         (cfg_data),
        .port_enable      (port_enable),
        .out_valid        (out_valid),
        .out_ingress_port (out_ingress_port),
        .out_egress_port  (out_egress_port),
        .out_prio         (out_prio),
        .out_byte_length  (out_byte_length),
        .out_drop_mark    (out_drop_mark)
    );

    always #5 core_clk_ifc = ~core_clk_ifc;

    //////////////////////////////
    // Random numbers and table
    //////////////////////////////

    // Galois LFSR with taps 32 22 2 1, stepped once per bit
    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic phase_t make_phase(input policer_pkg::rate_t cir, input logic cir_rnd,
                                          input policer_pkg::depth_t cbs, input logic cbs_rnd,
                                          input logic [NUM_PORTS-1:0] mask, input logic mask_rnd,
                                          input int count, input int gap_after,
                                          input int gap_cycles, input logic rate_mode);
        phase_t p;
        p.cir         = cir;
        p.cir_random  = cir_rnd;
        p.cbs         = cbs;
        p.cbs_random  = cbs_rnd;
        p.enable_mask = mask;
        p.mask_random = mask_rnd;
        p.pkt_count   = count;
        p.len_random  = !rate_mode;
        p.fixed_len   = policer_pkg::byte_len_t'(1000);
        p.gap_after   = gap_after;
        p.gap_cycles  = gap_cycles;
        p.rate_mode   = rate_mode;
        return p;
    endfunction

    // Rate phase waits assume the slowest random CIR of one byte per cycle
    function automatic int compute_timeout();
        int total;
        total = 16;
        for (int i = 0; i < NUM_PHASES; i++) begin
            total += 40 + phases[i].pkt_count + phases[i].gap_cycles;
            if (phases[i].rate_mode) begin
                total += NUM_PORTS * (992 + 1000 + 2);
            end
        end
        return 2 * total + 200;
    endfunction

    //////////////////////////////
    // Failure reporting and checks
    //////////////////////////////

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("Error at time %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "wrong value on a DUT output");
    endtask

    task automatic report_stream_error(input string msg);
        error_count++;
        $display("%s, at time %0t", msg, $time);
        $display("TB FAILED");
        $fatal(1, "output stream out of step with the model");
    endtask

    task automatic check_desc(input policer_pkg::port_t got_ing, input policer_pkg::port_t exp_ing,
                              input policer_pkg::port_t got_egr, input policer_pkg::port_t exp_egr,
                              input policer_pkg::prio_t got_prio, input policer_pkg::prio_t exp_prio,
                              input policer_pkg::byte_len_t got_len,
                              input policer_pkg::byte_len_t exp_len);
        if (got_ing !== exp_ing) begin
            report_mismatch($sformatf("ingress port %0d, expected %0d", got_ing, exp_ing));
        end
        if (got_egr !== exp_egr) begin
            report_mismatch($sformatf("egress port %0d, expected %0d", got_egr, exp_egr));
        end
        if (got_prio !== exp_prio) begin
            report_mismatch($sformatf("priority %0d, expected %0d", got_prio, exp_prio));
        end
        if (got_len !== exp_len) begin
            report_mismatch($sformatf("byte length %0d, expected %0d", got_len, exp_len));
        end
    endtask

    task automatic check_mark(input logic got, input logic expected, input policer_pkg::port_t port);
        if (got !== expected) begin
            report_mismatch($sformatf("drop mark %0b on port %0d, expected %0b", got, port,
                                      expected));
        end
    endtask

    //////////////////////////////
    // Reference model and output check
    //////////////////////////////

    // Inputs and outputs are read before this edge's updates land
    always @(posedge core_clk_ifc) begin : model
        policer_pkg::fill_t leaked [NUM_PORTS];
        exp_t               e;
        int                 p;
        int                 whole;
        if (timer_reset) begin
            exp_q.delete();
            m_s1_valid = 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                m_fill[i] = '0;
                m_cir[i]  = '0;
                m_cbs[i]  = '0;
            end
        end else begin
            if (out_valid && exp_q.size() == 0) begin
                report_stream_error("out_valid was high with no descriptor outstanding");
            end else if (out_valid) begin
                e = exp_q.pop_front();
                check_desc(out_ingress_port, e.ingress, out_egress_port, e.egress,
                           out_prio, e.prio, out_byte_length, e.len);
                check_mark(out_drop_mark, e.mark, e.ingress);
                checked_count++;
            end else if (exp_q.size() != 0) begin
                report_stream_error("out_valid did not come two cycles after a descriptor");
            end
            // Each bucket drains by its CIR and stops at empty
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (m_fill[i] > policer_pkg::fill_t'(m_cir[i])) begin
                    leaked[i] = m_fill[i] - policer_pkg::fill_t'(m_cir[i]);
                end else begin
                    leaked[i] = '0;
                end
            end
            if (m_s1_valid) begin
                e = m_s1_desc;
                p = int'(e.ingress);
                whole = int'(leaked[p] >> policer_pkg::RATE_FRAC_W);
                e.mark = m_s1_enable && (whole + int'(e.len) > int'(m_s1_cbs));
                if (m_s1_enable && !e.mark) begin
                    leaked[p] += policer_pkg::fill_t'(e.len) << policer_pkg::RATE_FRAC_W;
                end
                exp_q.push_back(e);
            end
            m_fill = leaked;
            m_s1_valid = pkt_valid;
            m_s1_desc = '{pkt_ingress_port, pkt_egress_port, pkt_prio, pkt_byte_length, 1'b0};
            m_s1_enable = 1'b0;
            m_s1_cbs = '0;
            if (int'(pkt_ingress_port) < NUM_PORTS) begin
                m_s1_enable = port_enable[pkt_ingress_port];
                m_s1_cbs = m_cbs[pkt_ingress_port];
            end
            if (cfg_write && int'(cfg_port) < NUM_PORTS) begin
                if (cfg_sel == policer_pkg::CFG_SEL_CIR) begin
                    m_cir[cfg_port] = cfg_data[15:0];
                end else begin
                    m_cbs[cfg_port] = cfg_data[19:0];
                end
            end
        end
    end

    always @(posedge core_clk_ifc) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not end within %0d cycles", timeout_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge core_clk_ifc);
            pkt_valid <= 1'b0;
        end
    endtask

    task automatic send_packet(input policer_pkg::port_t port, input policer_pkg::byte_len_t len);
        @(posedge core_clk_ifc);
        pkt_valid        <= 1'b1;
        pkt_ingress_port <= port;
        pkt_egress_port  <= policer_pkg::port_t'(random_bits(4));
        pkt_prio         <= policer_pkg::prio_t'(random_bits(3));
        pkt_byte_length  <= len;
        sent_count++;
    endtask

    task automatic write_cfg(input policer_pkg::cfg_sel_t sel, input int port,
                             input logic [31:0] data);
        @(posedge core_clk_ifc);
        cfg_write <= 1'b1;
        cfg_sel   <= sel;
        cfg_port  <= policer_pkg::port_t'(port);
        cfg_data  <= data;
    endtask

    task automatic wait_drain();
        while (checked_count != sent_count) begin
            @(posedge core_clk_ifc);
        end
    endtask

    task automatic run_phase(input phase_t ph);
        policer_pkg::rate_t     cir_v [NUM_PORTS];
        policer_pkg::depth_t    cbs_v;
        policer_pkg::byte_len_t len;
        int                     mark_wait;
        int                     drain_wait;
        int unsigned            r;
        wait_drain();
        @(posedge core_clk_ifc);
        timer_reset <= 1'b1;
        idle(2);
        timer_reset <= 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            // Random CIR kept between 1 and 5 bytes per cycle
            cir_v[i] = ph.cir_random ? policer_pkg::rate_t'(16'h0100 + random_bits(10)) : ph.cir;
            cbs_v = ph.cbs_random ? policer_pkg::depth_t'(random_bits(14)) : ph.cbs;
            write_cfg(policer_pkg::CFG_SEL_CIR, i, {16'b0, cir_v[i]});
            write_cfg(policer_pkg::CFG_SEL_CBS, i, {12'b0, cbs_v});
        end
        @(posedge core_clk_ifc);
        cfg_write <= 1'b0;
        r = random_bits(NUM_PORTS);
        port_enable <= ph.mask_random ? r[NUM_PORTS-1:0] : ph.enable_mask;
        if (ph.rate_mode) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                // Second packet meets about 8 bytes and the third an empty bucket
                mark_wait  = (992 << policer_pkg::RATE_FRAC_W) / int'(cir_v[i]);
                drain_wait = ((1000 << policer_pkg::RATE_FRAC_W) + int'(cir_v[i]) - 1)
                             / int'(cir_v[i]);
                send_packet(policer_pkg::port_t'(i), ph.fixed_len);
                idle(mark_wait - 1);
                send_packet(policer_pkg::port_t'(i), ph.fixed_len);
                idle(drain_wait - 1);
                send_packet(policer_pkg::port_t'(i), ph.fixed_len);
            end
        end else begin
            for (int n = 0; n < ph.pkt_count; n++) begin
                len = ph.fixed_len;
                if (ph.len_random) begin
                    len = policer_pkg::byte_len_t'(policer_pkg::MIN_PKT_BYTES + random_bits(11)
                          % (policer_pkg::MTU_BYTES - policer_pkg::MIN_PKT_BYTES + 1));
                end
                send_packet(policer_pkg::port_t'(random_bits(4) % NUM_PORTS), len);
                if (n == ph.gap_after) begin
                    idle(ph.gap_cycles);
                end
            end
        end
        idle(1);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        core_clk_ifc     = 1'b0;
        timer_reset      = 1'b1;
        pkt_valid        = 1'b0;
        pkt_ingress_port = '0;
        pkt_egress_port  = '0;
        pkt_prio         = '0;
        pkt_byte_length  = '0;
        cfg_write        = 1'b0;
        cfg_sel          = policer_pkg::CFG_SEL_CIR;
        cfg_port         = '0;
        cfg_data         = '0;
        port_enable      = '0;
        lfsr_state       = LFSR_SEED;
        sent_count       = 0;
        checked_count    = 0;
        error_count      = 0;
        cycle_count      = 0;

        // Accept all, mark all, disable, burst, rate
        phases[0] = make_phase(16'hFFFF, 0, 20'hFFFFF, 0, ALL_PORTS, 0, 300, -1, 0, 0);
        phases[1] = make_phase(16'h0000, 0, 20'h00000, 0, ALL_PORTS, 0, 100, -1, 0, 0);
        phases[2] = make_phase(16'h0000, 0, 20'h00000, 0, ALL_PORTS, 1, 150, -1, 0, 0);
        phases[3] = make_phase(16'h0000, 0, 20'h00000, 1, ALL_PORTS, 0, 300, 150, 20, 0);
        phases[4] = make_phase(16'h0000, 1, 20'd1000, 0, ALL_PORTS, 0, 3 * NUM_PORTS, -1, 0, 1);
        timeout_limit = compute_timeout();

        repeat (16) @(posedge core_clk_ifc);
        timer_reset <= 1'b0;
        for (int i = 0; i < NUM_PHASES; i++) begin
            run_phase(phases[i]);
        end
        wait_drain();
        idle(2);

        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/policer_pkg.sv
hw/policer_bucket_if.sv
hw/policer_config_regs.sv
hw/policer_bucket_bank.sv
hw/policer_marker.sv
hw/policer_top.sv
tests/policer_tb_asserts.sv
tests/policer_tb.sv

/* Makefile */
# Verilator build and run of the policer testbench

SIM := obj_dir/Vpolicer_tb

.PHONY: all run lint clean

all: run

$(SIM): verilog.f hw/*.sv tests/*.sv
	verilator --binary --assert --top-module policer_tb -f verilog.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --top-module policer_tb -f verilog.f
	verilator --lint-only --top-module policer_top hw/policer_pkg.sv hw/policer_bucket_if.sv \
		hw/policer_config_regs.sv hw/policer_bucket_bank.sv hw/policer_marker.sv hw/policer_top.sv

clean:
	rm -rf obj_dir sim.log
